// File: Makefile
VERILATOR ?= verilator
TOP       ?= ciUnitTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: common/ciDecodedIf.sv
`timescale 1ns/1ns

interface ciDecodedIf import ciPkg::*; ();

  logic       valid;
  logic       ready;
  ciOp_e      op;
  ciOperand_u operandA;
  ciOperand_u operandB;

  modport source (
    output valid, op, operandA, operandB,
    input  ready
  );

  modport sink (
    input  valid, op, operandA, operandB,
    output ready
  );

endinterface

// File: common/ciExecutedIf.sv
`timescale 1ns/1ns

interface ciExecutedIf import ciPkg::*; ();

  logic    valid;
  logic    ready;
  ciWord_t result;
  // set for an instruction number nobody claims
  logic    unknownId;

  modport source (
    output valid, result, unknownId,
    input  ready
  );

  modport sink (
    input  valid, result, unknownId,
    output ready
  );

endinterface

// File: common/ciPkg.sv
package ciPkg;

  typedef logic [31:0] ciWord_t;
  typedef logic [7:0]  ciId_t;

  // red sits in the top bits
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef struct packed {
    rgb565_t hi;
    rgb565_t lo;
  } pixelPair_t;

  // one operand word, seen as bytes or as two pixels
  typedef union packed {
    logic [3:0][7:0] bytes;
    pixelPair_t      pixels;
  } ciOperand_u;

  typedef enum logic [2:0] {
    opNone,
    opSwap,
    opGray,
    opGrayQuad,
    opProfile
  } ciOp_e;

  localparam int NUM_COUNTERS = 4;

  // luma weights 77/150/29 over 256
  function automatic logic [7:0] rgbToGray(input rgb565_t pixel);
    logic [15:0] red;
    logic [15:0] green;
    logic [15:0] blue;
    logic [15:0] sum;
    red   = {8'd0, pixel.red, 3'b000};
    green = {8'd0, pixel.green, 2'b00};
    blue  = {8'd0, pixel.blue, 3'b000};
    sum   = 16'd77 * red + 16'd150 * green + 16'd29 * blue;
    return sum[15:8];
  endfunction

endpackage

// File: execute/ciExecute.sv
`timescale 1ns/1ns

module ciExecute import ciPkg::*; #(
  parameter int counterWidth = 32
) (
  input  logic        s_systemClock,
  input  logic        s_pllLocked,
  input  logic        stall,
  input  logic        busIdle,
  ciDecodedIf.sink    decoded,
  ciExecutedIf.source executed
);

  logic    validReg;
  logic    unknownReg;
  ciWord_t resultReg;
  ciWord_t resultNext;
  logic    unknownNext;
  ciWord_t counterValue;
  logic    load;
  logic    profileCommand;
  logic    instrDone;

  assign decoded.ready  = ~validReg | executed.ready;
  assign load           = decoded.valid & decoded.ready;
  // counters act on the edge the profile instruction moves on
  assign profileCommand = load & (decoded.op == opProfile);
  assign instrDone      = executed.valid & executed.ready;

  profileCounters #(
    .counterWidth(counterWidth)
  ) counters (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .stall        (stall),
    .busIdle      (busIdle),
    .instrDone    (instrDone),
    .command      (profileCommand),
    .select       (decoded.operandA.bytes[0][1:0]),
    .startMask    (decoded.operandB.bytes[0][3:0]),
    .stopMask     (decoded.operandB.bytes[0][7:4]),
    .clearMask    (decoded.operandB.bytes[1][3:0]),
    .value        (counterValue)
  );

  always_comb begin
    resultNext  = '0;
    unknownNext = 1'b0;
    case (decoded.op)
      opSwap: resultNext = {decoded.operandA.bytes[0], decoded.operandA.bytes[1],
                            decoded.operandA.bytes[2], decoded.operandA.bytes[3]};
      opGray: resultNext = {24'd0, rgbToGray(decoded.operandA.pixels.lo)};
      // byte 0 from A.lo up to byte 3 from B.hi
      opGrayQuad: resultNext = {rgbToGray(decoded.operandB.pixels.hi),
                                rgbToGray(decoded.operandB.pixels.lo),
                                rgbToGray(decoded.operandA.pixels.hi),
                                rgbToGray(decoded.operandA.pixels.lo)};
      opProfile: resultNext = counterValue;
      default: unknownNext = 1'b1;
    endcase
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) validReg <= 1'b0;
    else validReg <= load | (validReg & ~executed.ready);
  end

  always_ff @(posedge s_systemClock) begin
    if (load) begin
      resultReg  <= resultNext;
      unknownReg <= unknownNext;
    end
  end

  assign executed.valid     = validReg;
  assign executed.result    = resultReg;
  assign executed.unknownId = unknownReg;

endmodule

// File: execute/profileCounters.sv
`timescale 1ns/1ns

module profileCounters import ciPkg::*; #(
  parameter int counterWidth = 32
) (
  input  logic                            s_systemClock,
  input  logic                            s_pllLocked,
  input  logic                            stall,
  input  logic                            busIdle,
  input  logic                            instrDone,
  input  logic                            command,
  input  logic [$clog2(NUM_COUNTERS)-1:0] select,
  input  logic [NUM_COUNTERS-1:0]         startMask,
  input  logic [NUM_COUNTERS-1:0]         stopMask,
  input  logic [NUM_COUNTERS-1:0]         clearMask,
  output ciWord_t                         value
);

  logic [counterWidth-1:0] counters [NUM_COUNTERS];
  logic [NUM_COUNTERS-1:0] running;
  logic [NUM_COUNTERS-1:0] events;

  // cycles, stall cycles, bus idle cycles, finished instructions
  assign events = {instrDone, busIdle, stall, 1'b1};

  // narrow counters read back zero-extended
  assign value = ciWord_t'(counters[select]);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      running <= '0;
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        counters[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        // clear beats counting
        if (command & clearMask[i]) begin
          counters[i] <= '0;
        end else if (running[i] & events[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end

        // start beats stop
        if (command & startMask[i]) begin
          running[i] <= 1'b1;
        end else if (command & stopMask[i]) begin
          running[i] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: sim/ciUnitTb.sv
`timescale 1ns/1ns

module ciUnitTb;

  localparam int CLOCK_PERIOD = 10;
  // under 100 instructions at a few cycles each fit well inside 2000
  localparam int MAX_CYCLES = 2000;
  localparam logic [7:0] SWAP_ID = 8'd1;
  localparam logic [7:0] GRAY_ID = 8'd12;
  localparam logic [7:0] QUAD_ID = 8'd13;
  localparam logic [7:0] PROFILE_ID = 8'd8;
  localparam logic [7:0] BAD_ID = 8'd99;

  logic        s_systemClock;
  logic        s_pllLocked;
  logic        reqValid;
  logic [7:0]  ciN;
  logic [31:0] ciDataA;
  logic [31:0] ciDataB;
  logic        stall;
  logic        busIdle;
  logic        rspReady;
  logic        reqReady;
  logic        rspValid;
  logic [31:0] rspResult;
  logic        rspUnknownId;

  // expected responses in order of issue
  logic [31:0] expectedResult [$];
  logic        expectedUnknown [$];
  logic        expectedCapture [$];
  string       expectedName [$];
  logic [31:0] readings [$];
  logic [31:0] dataState;
  logic [31:0] readyState;
  logic        backPressure;
  int          errorCount;
  int          checkCount;
  int          testErrors;
  int          cycleCount;

  customInstructionUnit DUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .reqValid     (reqValid),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .stall        (stall),
    .busIdle      (busIdle),
    .rspReady     (rspReady),
    .reqReady     (reqReady),
    .rspValid     (rspValid),
    .rspResult    (rspResult),
    .rspUnknownId (rspUnknownId)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(CLOCK_PERIOD / 2) s_systemClock = ~s_systemClock;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] nextData();
    dataState = lcgNext(dataState);
    return dataState;
  endfunction

  // widened channels weighted 77/150/29 and divided by 256
  function automatic logic [7:0] grayOf(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    int sum;
    red   = 32'(pixel[15:11]) * 8;
    green = 32'(pixel[10:5]) * 4;
    blue  = 32'(pixel[4:0]) * 8;
    sum   = (77 * red + 150 * green + 29 * blue) / 256;
    return 8'(sum);
  endfunction

  function automatic logic [31:0] swapBytes(input logic [31:0] word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  task automatic issue(input logic [7:0] id, input logic [31:0] a, input logic [31:0] b,
                       input logic [31:0] result, input logic unknown, input logic capture,
                       input string name);
    reqValid = 1'b1;
    ciN      = id;
    ciDataA  = a;
    ciDataB  = b;
    expectedResult.push_back(result);
    expectedUnknown.push_back(unknown);
    expectedCapture.push_back(capture);
    expectedName.push_back(name);
    @(posedge s_systemClock);
    while (!reqReady) @(posedge s_systemClock);
    #1;
    reqValid = 1'b0;
  endtask

  task automatic drain();
    @(posedge s_systemClock);
    #1;
    while (expectedResult.size() != 0) begin
      @(posedge s_systemClock);
      #1;
    end
  endtask

  task automatic idleCycles(input int count);
    repeat (count) @(posedge s_systemClock);
    #1;
  endtask

  task automatic finishTest(input string name);
    $display("test %s finished with %0d errors", name, errorCount - testErrors);
    testErrors = errorCount;
  endtask

  // response monitor samples before the edge updates the outputs
  always @(posedge s_systemClock) begin
    if (s_pllLocked && rspValid && rspReady) begin
      if (expectedResult.size() == 0) begin
        errorCount++;
        $display("response at %0t arrived with no request outstanding", $time);
      end else begin
        if (expectedCapture[0]) begin
          readings.push_back(rspResult);
        end else begin
          checkCount++;
          assert (rspResult === expectedResult[0] && rspUnknownId === expectedUnknown[0])
          else begin
            errorCount++;
            $display("Error at %0t: %s gave %h unknown %b, expected %h unknown %b", $time,
                     expectedName[0], rspResult, rspUnknownId, expectedResult[0],
                     expectedUnknown[0]);
          end
        end
        void'(expectedResult.pop_front());
        void'(expectedUnknown.pop_front());
        void'(expectedCapture.pop_front());
        void'(expectedName.pop_front());
      end
    end
  end

  // consumer drops rspReady at random while back-pressure is on
  always @(posedge s_systemClock) begin
    #1;
    if (backPressure) begin
      readyState = lcgNext(readyState);
      rspReady = readyState[16];
    end else begin
      rspReady = 1'b1;
    end
  end

  always @(posedge s_systemClock) begin
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d responses missing", cycleCount,
               expectedResult.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pick;
    s_pllLocked  = 1'b1;
    reqValid     = 1'b0;
    ciN          = 8'd0;
    ciDataA      = 32'd0;
    ciDataB      = 32'd0;
    stall        = 1'b0;
    busIdle      = 1'b0;
    rspReady     = 1'b1;
    backPressure = 1'b0;
    dataState    = 32'd59;
    readyState   = ~32'd59;
    errorCount   = 0;
    checkCount   = 0;
    testErrors   = 0;
    cycleCount   = 0;
    #1;
    s_pllLocked = 1'b0;
    repeat (16) @(posedge s_systemClock);
    #1;
    s_pllLocked = 1'b1;
    idleCycles(2);

    for (int i = 0; i < 20; i++) begin
      a = nextData();
      issue(SWAP_ID, a, nextData(), swapBytes(a), 1'b0, 1'b0, $sformatf("swap %h", a));
    end
    drain();
    finishTest("byte swap");

    for (int i = 0; i < 10; i++) begin
      a = nextData();
      b = nextData();
      issue(GRAY_ID, a, b, {24'd0, grayOf(a[15:0])}, 1'b0, 1'b0, $sformatf("gray %h", a));
      issue(QUAD_ID, a, b, {grayOf(b[31:16]), grayOf(b[15:0]), grayOf(a[31:16]),
            grayOf(a[15:0])}, 1'b0, 1'b0, $sformatf("quad %h %h", a, b));
    end
    issue(GRAY_ID, '1, '1, {24'd0, grayOf(16'hffff)}, 1'b0, 1'b0, "gray all ones");
    issue(QUAD_ID, '1, '1, {4{grayOf(16'hffff)}}, 1'b0, 1'b0, "quad all ones");
    issue(GRAY_ID, '0, '0, 32'd0, 1'b0, 1'b0, "gray all zeros");
    issue(QUAD_ID, '0, '0, 32'd0, 1'b0, 1'b0, "quad all zeros");
    drain();
    finishTest("grayscale");

    readings.delete();
    issue(PROFILE_ID, 32'd0, 32'h00f, 32'd0, 1'b0, 1'b1, "start all");
    issue(PROFILE_ID, 32'd0, 32'hf00, 32'd0, 1'b0, 1'b1, "clear all");
    drain();
    idleCycles(4);
    issue(PROFILE_ID, 32'd0, 32'd0, 32'd0, 1'b0, 1'b1, "read cycles");
    idleCycles(5);
    issue(PROFILE_ID, 32'd0, 32'd0, 32'd0, 1'b0, 1'b1, "read cycles");
    issue(PROFILE_ID, 32'd0, 32'h010, 32'd0, 1'b0, 1'b1, "stop cycles");
    drain();
    issue(PROFILE_ID, 32'd0, 32'd0, 32'd0, 1'b0, 1'b1, "read stopped");
    idleCycles(5);
    issue(PROFILE_ID, 32'd0, 32'd0, 32'd0, 1'b0, 1'b1, "read stopped");
    issue(PROFILE_ID, 32'd1, 32'd0, 32'd0, 1'b0, 1'b1, "read stall");
    drain();
    checkCount += 4;
    assert (readings.size() == 8)
    else begin
      errorCount++;
      $display("expected 8 counter reads, got %0d", readings.size());
    end
    assert (readings[3] > readings[2])
    else begin
      errorCount++;
      $display("Error at %0t: cycle counter did not advance, %0d then %0d", $time,
               readings[2], readings[3]);
    end
    assert (readings[5] == readings[6])
    else begin
      errorCount++;
      $display("Error at %0t: stopped counter moved, %0d then %0d", $time,
               readings[5], readings[6]);
    end
    assert (readings[7] == 32'd0)
    else begin
      errorCount++;
      $display("Error at %0t: stall counter reads %0d with stall low", $time, readings[7]);
    end
    finishTest("profiling counters");

    issue(BAD_ID, nextData(), nextData(), 32'd0, 1'b1, 1'b0, "unknown id");
    a = nextData();
    issue(SWAP_ID, a, 32'd0, swapBytes(a), 1'b0, 1'b0, $sformatf("swap after unknown %h", a));
    drain();
    finishTest("unknown id");

    backPressure = 1'b1;
    for (int i = 0; i < 40; i++) begin
      pick = nextData();
      a = nextData();
      b = nextData();
      case (pick[1:0])
        2'd0: issue(SWAP_ID, a, b, swapBytes(a), 1'b0, 1'b0, $sformatf("swap %h", a));
        2'd1: issue(GRAY_ID, a, b, {24'd0, grayOf(a[15:0])}, 1'b0, 1'b0,
                    $sformatf("gray %h", a));
        2'd2: issue(QUAD_ID, a, b, {grayOf(b[31:16]), grayOf(b[15:0]), grayOf(a[31:16]),
                    grayOf(a[15:0])}, 1'b0, 1'b0, $sformatf("quad %h %h", a, b));
        default: issue(8'd200, a, b, 32'd0, 1'b1, 1'b0, "unknown id 200");
      endcase
    end
    backPressure = 1'b0;
    drain();
    finishTest("back-pressure mix");

    errorCount += DUT.protocolChecker.failures;
    $display("5 tests, %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sim/ciUnit_checker.sv
`timescale 1ns/1ns

module ciUnitChecker import ciPkg::*; (
  input logic    s_systemClock,
  input logic    s_pllLocked,
  input logic    reqValid,
  input logic    reqReady,
  input logic    rspValid,
  input logic    rspReady,
  input ciWord_t rspResult,
  input logic    rspUnknownId
);

  int         failures = 0;
  logic [2:0] outstanding;
  logic       accepted;
  logic       returned;

  assign accepted = reqValid & reqReady;
  assign returned = rspValid & rspReady;

  // requests accepted but not yet answered
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      outstanding <= 3'd0;
    end else if (accepted & ~returned) begin
      outstanding <= outstanding + 3'd1;
    end else if (~accepted & returned) begin
      outstanding <= outstanding - 3'd1;
    end
  end

  // held response keeps valid and data
  assert property (@(posedge s_systemClock) disable iff (~s_pllLocked)
    rspValid & ~rspReady |=> rspValid && $stable(rspResult) && $stable(rspUnknownId))
  else begin
    failures++;
    $error("response changed or dropped before the consumer took it");
  end

  assert property (@(posedge s_systemClock) ~s_pllLocked |-> ~reqReady && ~rspValid)
  else begin
    failures++;
    $error("handshake signal high while reset is active");
  end

  // three pipeline registers at most
  assert property (@(posedge s_systemClock) disable iff (~s_pllLocked) outstanding <= 3'd3)
  else begin
    failures++;
    $error("more than three requests outstanding");
  end

endmodule

bind customInstructionUnit ciUnitChecker protocolChecker (
  .s_systemClock(s_systemClock),
  .s_pllLocked  (s_pllLocked),
  .reqValid     (reqValid),
  .reqReady     (reqReady),
  .rspValid     (rspValid),
  .rspReady     (rspReady),
  .rspResult    (rspResult),
  .rspUnknownId (rspUnknownId)
);

// File: src.f
common/ciPkg.sv
common/ciDecodedIf.sv
common/ciExecutedIf.sv
verilog/ciDecoder.sv
execute/profileCounters.sv
execute/ciExecute.sv
verilog/ciResult.sv
verilog/customInstructionUnit.sv
sim/ciUnit_checker.sv
sim/ciUnitTb.sv

// File: verilog/ciDecoder.sv
`timescale 1ns/1ns

module ciDecoder import ciPkg::*; #(
  parameter ciId_t swapId     = 8'd1,
  parameter ciId_t grayId     = 8'd12,
  parameter ciId_t grayQuadId = 8'd13,
  parameter ciId_t profileId  = 8'd8
) (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  input  logic          reqValid,
  input  ciId_t         ciN,
  input  ciWord_t       ciDataA,
  input  ciWord_t       ciDataB,
  output logic          reqReady,
  ciDecodedIf.source    decoded
);

  logic       validReg;
  logic       resetDone;
  logic       load;
  ciOp_e      opNext;
  ciOp_e      opReg;
  ciOperand_u operandAReg;
  ciOperand_u operandBReg;

  // held low for the reset cycle, then follows occupancy
  assign reqReady = resetDone & (~validReg | decoded.ready);
  assign load     = reqValid & reqReady;

  always_comb begin
    if (ciN == swapId) opNext = opSwap;
    else if (ciN == grayId) opNext = opGray;
    else if (ciN == grayQuadId) opNext = opGrayQuad;
    else if (ciN == profileId) opNext = opProfile;
    else opNext = opNone;
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      resetDone <= 1'b0;
      validReg  <= 1'b0;
    end else begin
      resetDone <= 1'b1;
      validReg  <= load | (validReg & ~decoded.ready);
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (load) begin
      opReg       <= opNext;
      operandAReg <= ciDataA;
      operandBReg <= ciDataB;
    end
  end

  assign decoded.valid    = validReg;
  assign decoded.op       = opReg;
  assign decoded.operandA = operandAReg;
  assign decoded.operandB = operandBReg;

endmodule

// File: verilog/ciResult.sv
`timescale 1ns/1ns

module ciResult import ciPkg::*; (
  input  logic      s_systemClock,
  input  logic      s_pllLocked,
  input  logic      rspReady,
  ciExecutedIf.sink executed,
  output logic      rspValid,
  output ciWord_t   rspResult,
  output logic      rspUnknownId
);

  logic load;

  // a full register only frees up when the consumer takes it
  assign executed.ready = ~rspValid | rspReady;
  assign load           = executed.valid & executed.ready;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) rspValid <= 1'b0;
    else rspValid <= load | (rspValid & ~rspReady);
  end

  always_ff @(posedge s_systemClock) begin
    if (load) begin
      rspResult    <= executed.result;
      rspUnknownId <= executed.unknownId;
    end
  end

endmodule

// File: verilog/customInstructionUnit.sv
`timescale 1ns/1ns

module customInstructionUnit import ciPkg::*; #(
  parameter ciId_t swapId       = 8'd1,
  parameter ciId_t grayId       = 8'd12,
  parameter ciId_t grayQuadId   = 8'd13,
  parameter ciId_t profileId    = 8'd8,
  parameter int    counterWidth = 32
) (
  input  logic    s_systemClock,
  input  logic    s_pllLocked,
  input  logic    reqValid,
  input  ciId_t   ciN,
  input  ciWord_t ciDataA,
  input  ciWord_t ciDataB,
  input  logic    stall,
  input  logic    busIdle,
  input  logic    rspReady,
  output logic    reqReady,
  output logic    rspValid,
  output ciWord_t rspResult,
  output logic    rspUnknownId
);

  ciDecodedIf  decodedBus ();
  ciExecutedIf executedBus ();

  ciDecoder #(
    .swapId    (swapId),
    .grayId    (grayId),
    .grayQuadId(grayQuadId),
    .profileId (profileId)
  ) decoder (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .reqValid     (reqValid),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .reqReady     (reqReady),
    .decoded      (decodedBus)
  );

  ciExecute #(
    .counterWidth(counterWidth)
  ) execute (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .stall        (stall),
    .busIdle      (busIdle),
    .decoded      (decodedBus),
    .executed     (executedBus)
  );

  // output stage, holds the response under back-pressure
  ciResult result (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .rspReady     (rspReady),
    .executed     (executedBus),
    .rspValid     (rspValid),
    .rspResult    (rspResult),
    .rspUnknownId (rspUnknownId)
  );

endmodule
